// ==== sim.f ====
+incdir+verif
verilog/rob_pkg.sv
verilog/rob_entry_array.sv
verilog/rob_pointers.sv
verilog/rob_resolve.sv
verilog/rob_retire.sv
verilog/rob_top.sv
verif/rob_tb.sv

// ==== verif/rob_tests.svh ====
//////////////////////////////////////////////////
// Drivers and response waits
//////////////////////////////////////////////////

task automatic send_dispatch(word_t pc, reg_addr_t rd, logic branch, logic jump,
                             logic mem, logic predict, word_t target);
    check_id(dispatch_id, next_id);
    dispatch = '{valid: 1'b1, pc: pc, rd_addr: rd, branch_inst: branch, jump_inst: jump,
                 mem_inst: mem, predict_taken: predict, branch_target: target};
    next_cycle();
    dispatch = '0;
    next_id  = next_id + 1'b1;
endtask

task automatic send_result(logic to_mem, rob_id_t id, word_t data);
    if (to_mem) begin
        mem_result = '{valid: 1'b1, rob_id: id, data: data};
    end else begin
        ex_result = '{valid: 1'b1, rob_id: id, data: data};
    end
    next_cycle();
    ex_result  = '0;
    mem_result = '0;
endtask

task automatic expect_quiet(int cycles);
    repeat (cycles) begin
        next_cycle();
        if (reg_write.valid) begin
            abort_run($sformatf("Unexpected register write from ROB id %0d", reg_write.rob_id));
        end
        check_redirect(redirect, NO_MISS);
    end
endtask

// Waits for the next retirement, which may take a variable number of cycles
task automatic expect_retire(rob_id_t id, reg_addr_t rd, word_t data, redirect_t exp_redirect);
    reg_write_t exp;
    exp = '{valid: 1'b1, rob_id: id, rd_addr: rd, rd_data: data};
    do begin
        next_cycle();
    end while (!reg_write.valid);
    check_reg_write(reg_write, exp);
    check_redirect(redirect, exp_redirect);
    if (exp_redirect.miss) begin
        // One flush cycle before the buffer is empty
        expect_quiet(1);
        next_id = '0;
        check_id(dispatch_id, next_id);
    end
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic check_reset_state();
    check_id(dispatch_id, '0);
    check_full(full, 1'b0);
    check_redirect(redirect, NO_MISS);
    if (reg_write.valid !== 1'b0) begin
        abort_run("Register write is active right after reset");
    end
endtask

task automatic test_in_order_retire();
    reg_addr_t rd   [4];
    word_t     data [4];
    rob_id_t   id   [4];
    for (int i = 0; i < 4; i++) begin
        rd[i]   = reg_addr_t'(random_bits(5));
        data[i] = random_bits(32);
        id[i]   = next_id;
        send_dispatch(word_t'(32'h1000 + 4 * i), rd[i], 1'b0, 1'b0, 1'b0, 1'b0, '0);
    end
    // Youngest result first
    for (int i = 3; i >= 0; i--) begin
        send_result(1'b0, id[i], data[i]);
    end
    for (int i = 0; i < 4; i++) begin
        expect_retire(id[i], rd[i], data[i], NO_MISS);
    end
endtask

task automatic test_memory_completion();
    reg_addr_t rd;
    word_t     load_data;
    rob_id_t   id;
    rd        = reg_addr_t'(random_bits(5));
    load_data = random_bits(32);
    id        = next_id;
    send_dispatch(32'h2000, rd, 1'b0, 1'b0, 1'b1, 1'b0, '0);
    // Address result alone leaves the load pending
    send_result(1'b0, id, random_bits(32));
    expect_quiet(4);
    send_result(1'b1, id, load_data);
    expect_retire(id, rd, load_data, NO_MISS);
endtask

task automatic test_branch_prediction();
    word_t     outcome;
    rob_id_t   branch_id;
    rob_id_t   young_id;
    // Predicted taken and taken
    outcome   = random_bits(32) | 32'h1;
    branch_id = next_id;
    send_dispatch(32'h3000, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1, random_bits(32));
    send_result(1'b0, branch_id, outcome);
    expect_retire(branch_id, 5'd0, outcome, NO_MISS);

    // Predicted taken but falls through so the younger op is squashed
    outcome   = random_bits(32) & ~32'h1;
    branch_id = next_id;
    send_dispatch(32'h3100, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1, random_bits(32));
    young_id = next_id;
    send_dispatch(32'h3104, reg_addr_t'(random_bits(5)), 1'b0, 1'b0, 1'b0, 1'b0, '0);
    send_result(1'b0, young_id, random_bits(32));
    send_result(1'b0, branch_id, outcome);
    expect_retire(branch_id, 5'd0, outcome, redirect_t'{1'b1, 32'h3100 + 32'd4});
    expect_quiet(4);
endtask

task automatic test_jumps();
    word_t     jump_result;
    reg_addr_t rd;
    rob_id_t   id;
    // JAL links pc + 4 and goes to the result
    rd          = reg_addr_t'(random_bits(5));
    jump_result = random_bits(32);
    id          = next_id;
    send_dispatch(32'h4000, rd, 1'b0, 1'b1, 1'b0, 1'b0, '0);
    send_result(1'b0, id, jump_result);
    expect_retire(id, rd, 32'h4000 + 32'd4, redirect_t'{1'b1, jump_result});

    // JALR with an odd result drops bit 0 of the target
    rd          = reg_addr_t'(random_bits(5));
    jump_result = random_bits(32) | 32'h1;
    id          = next_id;
    send_dispatch(32'h4200, rd, 1'b1, 1'b1, 1'b0, 1'b0, '0);
    send_result(1'b0, id, jump_result);
    expect_retire(id, rd, 32'h4200 + 32'd4, redirect_t'{1'b1, jump_result & ~32'h1});
endtask

task automatic test_full_flag();
    reg_addr_t rd [6];
    rob_id_t   first_id;
    word_t     data;
    first_id = next_id;
    // Six dispatches with full low up to five entries and high at six
    for (int i = 0; i < 6; i++) begin
        rd[i] = reg_addr_t'(random_bits(5));
        send_dispatch(word_t'(32'h5000 + 4 * i), rd[i], 1'b0, 1'b0, 1'b0, 1'b0, '0);
        check_full(full, i == 5);
    end
    // Retiring the oldest frees one slot
    data = random_bits(32);
    send_result(1'b0, first_id, data);
    expect_retire(first_id, rd[0], data, NO_MISS);
    check_full(full, 1'b0);
endtask

// ==== verif/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb
    import rob_pkg::*;
();

    localparam int        TIMEOUT_CYCLES = 2000;
    localparam int        RESET_CYCLES   = 16;
    localparam word_t     LFSR_SEED      = 32'h8ece4872;
    localparam word_t     LFSR_TAPS      = 32'h80200003;
    localparam redirect_t NO_MISS        = '{miss: 1'b0, address: '0};

    logic       clk;
    logic       rst;
    dispatch_t  dispatch;
    result_t    ex_result;
    result_t    mem_result;
    rob_id_t    dispatch_id;
    logic       full;
    reg_write_t reg_write;
    redirect_t  redirect;

    word_t   lfsr_state = LFSR_SEED;
    // Id that the next dispatch should receive
    rob_id_t next_id;
    int      cycle_count;

    rob_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Galois LFSR stepped once per bit returned
    function automatic word_t random_bits(int unsigned width);
        word_t value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // Inputs change and outputs are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_reg_write(reg_write_t got, reg_write_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] reg_write got %h expected %h", got, exp));
        end
    endtask

    // Address only matters when a redirect is expected
    task automatic check_redirect(redirect_t got, redirect_t exp);
        if (got.miss !== exp.miss || (exp.miss && got.address !== exp.address)) begin
            abort_run($sformatf("[FAIL] redirect got %h expected %h", got, exp));
        end
    endtask

    task automatic check_id(rob_id_t got, rob_id_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] dispatch_id got %h expected %h", got, exp));
        end
    endtask

    task automatic check_full(logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] full got %h expected %h", got, exp));
        end
    endtask

    `include "rob_tests.svh"

    //////////////////////////////////////////////////
    // Timeout and test sequence
    //////////////////////////////////////////////////

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run("Run hung: the tests did not finish within the cycle limit");
    end

    initial begin
        dispatch   = '0;
        ex_result  = '0;
        mem_result = '0;
        next_id    = '0;
        rst        = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        check_reset_state();
        test_in_order_retire();
        test_memory_completion();
        test_branch_prediction();
        test_jumps();
        test_full_flag();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog/rob_top.sv ====
`timescale 1ns/1ps

module rob_top
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  dispatch_t  dispatch,
    input  result_t    ex_result,
    input  result_t    mem_result,
    output rob_id_t    dispatch_id,
    output logic       full,
    output reg_write_t reg_write,
    output redirect_t  redirect
);

    rob_id_t    head;
    rob_id_t    tail;
    rob_entry_t tail_entry;
    rob_entry_t ex_entry;
    rob_entry_t ex_update;
    logic       ex_update_en;
    logic       retire_fire;
    logic       flush;

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////

    rob_entry_array entry_array0 (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .head         (head),
        .tail         (tail),
        .dispatch     (dispatch),
        .ex_result    (ex_result),
        .ex_update    (ex_update),
        .ex_update_en (ex_update_en),
        .mem_result   (mem_result),
        .retire_fire  (retire_fire),
        .tail_entry   (tail_entry),
        .ex_entry     (ex_entry)
    );

    rob_pointers pointers0 (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch.valid),
        .retire_fire    (retire_fire),
        .head           (head),
        .tail           (tail),
        .full           (full)
    );

    //////////////////////////////////////////////////
    // Writeback and commit
    //////////////////////////////////////////////////

    rob_resolve resolve0 (
        .ex_result    (ex_result),
        .ex_entry     (ex_entry),
        .ex_update    (ex_update),
        .ex_update_en (ex_update_en)
    );

    rob_retire retire0 (
        .clk         (clk),
        .rst         (rst),
        .tail        (tail),
        .tail_entry  (tail_entry),
        .retire_fire (retire_fire),
        .flush       (flush),
        .reg_write   (reg_write),
        .redirect    (redirect)
    );

    // Next dispatch lands at the head
    assign dispatch_id = head;

endmodule

// ==== verilog/rob_retire.sv ====
`timescale 1ns/1ps

module rob_retire
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rob_id_t    tail,
    input  rob_entry_t tail_entry,
    output logic       retire_fire,
    output logic       flush,
    output reg_write_t reg_write,
    output redirect_t  redirect
);

    logic      branch_taken;
    logic      mispredict;
    logic      redirect_needed;
    word_t     redirect_next;

    logic      rw_valid;
    rob_id_t   rw_rob_id;
    reg_addr_t rw_rd_addr;
    word_t     rw_rd_data;
    logic      miss;
    word_t     miss_addr;

    // No retirement while the buffer is being flushed
    assign retire_fire = tail_entry.valid && tail_entry.done && !miss;

    assign branch_taken    = tail_entry.rd_data[0];
    assign mispredict      = tail_entry.branch_inst && !tail_entry.jump_inst &&
                             (branch_taken != tail_entry.predict_taken);
    assign redirect_needed = tail_entry.jump_inst || mispredict;

    always_comb begin
        if (tail_entry.jump_inst || branch_taken) begin
            redirect_next = tail_entry.target;
        end else begin
            redirect_next = tail_entry.pc + INST_BYTES;
        end
    end

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rw_valid <= 1'b0;
            miss     <= 1'b0;
        end else begin
            rw_valid <= retire_fire;
            miss     <= retire_fire && redirect_needed;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_fire) begin
            rw_rob_id  <= tail;
            rw_rd_addr <= tail_entry.rd_addr;
            rw_rd_data <= tail_entry.rd_data;
            miss_addr  <= redirect_next;
        end
    end

    assign reg_write = '{valid: rw_valid, rob_id: rw_rob_id,
                         rd_addr: rw_rd_addr, rd_data: rw_rd_data};
    assign redirect  = '{miss: miss, address: miss_addr};
    assign flush     = miss;

    // Pointers restart at entry zero once a flush has passed
    a_flush_resets_tail: assert property (
        @(posedge clk) disable iff (rst)
        flush |=> (tail == '0)
    );

endmodule

// ==== verilog/rob_resolve.sv ====
`timescale 1ns/1ps

module rob_resolve
    import rob_pkg::*;
(
    input  result_t    ex_result,
    input  rob_entry_t ex_entry,
    output rob_entry_t ex_update,
    output logic       ex_update_en
);

    logic  is_jalr;
    logic  is_jal;
    word_t link_addr;

    // JALR carries both the jump and branch flags
    assign is_jalr   = ex_entry.jump_inst && ex_entry.branch_inst;
    assign is_jal    = ex_entry.jump_inst && !ex_entry.branch_inst;
    assign link_addr = ex_entry.pc + INST_BYTES;

    // Results for flushed or never dispatched ids are dropped
    assign ex_update_en = ex_result.valid && ex_entry.valid;

    //////////////////////////////////////////////////
    // Result by instruction kind
    //////////////////////////////////////////////////

    always_comb begin
        ex_update = ex_entry;

        if (is_jalr) begin
            ex_update.target  = {ex_result.data[31:1], 1'b0};
            ex_update.rd_data = link_addr;
        end else if (is_jal) begin
            ex_update.target  = ex_result.data;
            ex_update.rd_data = link_addr;
        end else begin
            // Branches keep the decoded target and carry the taken flag in bit 0
            ex_update.rd_data = ex_result.data;
        end

        // Loads and stores wait for the memory bus
        ex_update.done = ex_entry.done || !ex_entry.mem_inst;
    end

endmodule

// ==== verilog/rob_pointers.sv ====
`timescale 1ns/1ps

module rob_pointers
    import rob_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    dispatch_valid,
    input  logic    retire_fire,
    output rob_id_t head,
    output rob_id_t tail,
    output logic    full
);

    rob_count_t count;

    //////////////////////////////////////////////////
    // Head, tail and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (dispatch_valid) begin
                head <= head + 1'b1;
            end
            if (retire_fire) begin
                tail <= tail + 1'b1;
            end

            // Dispatch and retire together cancel out
            if (dispatch_valid && !retire_fire) begin
                count <= count + 1'b1;
            end else if (retire_fire && !dispatch_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    // Advice to decode raised while FULL_MARGIN slots are still free
    assign full = (count >= rob_count_t'(ROB_DEPTH - FULL_MARGIN));

    // Decode has to honour full
    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (rst)
        full |-> !dispatch_valid
    );

    a_count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        count <= rob_count_t'(ROB_DEPTH)
    );

endmodule

// ==== verilog/rob_entry_array.sv ====
`timescale 1ns/1ps

module rob_entry_array
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  rob_id_t    head,
    input  rob_id_t    tail,
    input  dispatch_t  dispatch,
    input  result_t    ex_result,
    input  rob_entry_t ex_update,
    input  logic       ex_update_en,
    input  result_t    mem_result,
    input  logic       retire_fire,
    output rob_entry_t tail_entry,
    output rob_entry_t ex_entry
);

    rob_entry_t entries [ROB_DEPTH];
    rob_entry_t new_entry;
    logic       mem_hit;

    // Fresh entry built from the decode bus
    always_comb begin
        new_entry               = '0;
        new_entry.valid         = 1'b1;
        new_entry.done          = 1'b0;
        new_entry.branch_inst   = dispatch.branch_inst;
        new_entry.jump_inst     = dispatch.jump_inst;
        new_entry.mem_inst      = dispatch.mem_inst;
        new_entry.predict_taken = dispatch.predict_taken;
        new_entry.pc            = dispatch.pc;
        new_entry.rd_addr       = dispatch.rd_addr;
        new_entry.target        = dispatch.branch_target;
    end

    // Stale memory results for flushed entries are dropped
    assign mem_hit = mem_result.valid && entries[mem_result.rob_id].valid;

    //////////////////////////////////////////////////
    // Write ports
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            // Oldest entry leaves
            if (retire_fire) begin
                entries[tail].valid <= 1'b0;
            end

            if (dispatch.valid) begin
                entries[head] <= new_entry;
            end

            // Resolved execution fields
            if (ex_update_en) begin
                entries[ex_result.rob_id].done    <= ex_update.done;
                entries[ex_result.rob_id].rd_data <= ex_update.rd_data;
                entries[ex_result.rob_id].target  <= ex_update.target;
            end

            // Memory bus last so it wins a same-id collision
            if (mem_hit) begin
                entries[mem_result.rob_id].done    <= 1'b1;
                entries[mem_result.rob_id].rd_data <= mem_result.data;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    assign tail_entry = entries[tail];
    assign ex_entry   = entries[ex_result.rob_id];

    // Head from the pointer block must always point at a free slot
    a_dispatch_free: assert property (
        @(posedge clk) disable iff (rst)
        (dispatch.valid && !flush) |-> !entries[head].valid
    );

endmodule

// ==== verilog/rob_pkg.sv ====
package rob_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    localparam int ROB_ID_BITS = 3;
    localparam int ROB_DEPTH   = 8;

    // Free entries left when full is raised
    localparam int FULL_MARGIN = 2;

    // Byte step to the next sequential instruction
    localparam logic [31:0] INST_BYTES = 32'd4;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    typedef logic [ROB_ID_BITS-1:0] rob_id_t;
    typedef logic [ROB_ID_BITS:0]   rob_count_t;
    typedef logic [31:0]            word_t;
    typedef logic [4:0]             reg_addr_t;

    //////////////////////////////////////////////////
    // Buses
    //////////////////////////////////////////////////

    // Decode to ROB
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd_addr;
        logic      branch_inst;
        logic      jump_inst;
        logic      mem_inst;
        logic      predict_taken;
        word_t     branch_target;
    } dispatch_t;

    // Shared by the execution and memory writeback buses
    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        word_t   data;
    } result_t;

    typedef struct packed {
        logic      valid;
        logic      done;
        logic      branch_inst;
        logic      jump_inst;
        logic      mem_inst;
        logic      predict_taken;
        word_t     pc;
        reg_addr_t rd_addr;
        word_t     rd_data;
        word_t     target;
    } rob_entry_t;

    // Retire port toward the register file
    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        reg_addr_t rd_addr;
        word_t     rd_data;
    } reg_write_t;

    typedef struct packed {
        logic  miss;
        word_t address;
    } redirect_t;

endpackage
